/* hw/ctrl_consts.svh */
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

// Stage sequencing

`define NUM_STAGES 5 // Stages per instruction

// Bit positions in the one-hot stage vector
`define STAGE_FETCH   0
`define STAGE_DECODE  1
`define STAGE_EXECUTE 2
`define STAGE_MEMORY  3
`define STAGE_CONTROL 4

// Fetch bit alone, used at reset and on a fault restart
`define DEFAULT_STAGE_ACTIVE 5'b00001

// Trap causes

// Machine interrupt codes from the privileged spec
`define CAUSE_EXT_INT 4'd11 // Machine external interrupt
`define CAUSE_SW_INT  4'd3  // Machine software interrupt

// Width of the exception code field in mcause
`define CAUSE_WIDTH 4

// mcause as seen outside, interrupt flag on top of the code
`define MCAUSE_WIDTH (`CAUSE_WIDTH + 1)

`endif

/* hw/stage_pkg.sv */
`include "ctrl_consts.svh"

package stage_pkg;

    // One bit per stage, exactly one set at a time
    typedef logic [`NUM_STAGES-1:0] stage_vec_t;

    // Decision taken for the control stage
    typedef enum logic [1:0] {
        CTRL_TRAP    = 2'b00, // Synchronous exception
        CTRL_EXT_INT = 2'b01, // External interrupt
        CTRL_SW_INT  = 2'b10, // Software interrupt
        CTRL_NORMAL  = 2'b11  // No trap
    } control_op_e;

    // Fault number as captured by the sequencer.
    // Bit 2 marks a data side fault, bit 1 a store (or illegal op),
    // bit 0 an access fault rather than misalignment.
    // Value 3'b011 is never produced.
    typedef enum logic [2:0] {
        FAULT_INSTR_MISALIGNED = 3'b000,
        FAULT_INSTR_ACCESS     = 3'b001,
        FAULT_ILLEGAL_INSTR    = 3'b010,
        FAULT_LOAD_MISALIGNED  = 3'b100,
        FAULT_LOAD_ACCESS      = 3'b101,
        FAULT_STORE_MISALIGNED = 3'b110,
        FAULT_STORE_ACCESS     = 3'b111
    } fault_num_e;

    // Numeric value equals the RISC-V exception code
    typedef logic [`CAUSE_WIDTH-1:0] cause_t;

endpackage

/* hw/trap_pkg.sv */
package trap_pkg;

    // Fault flags raised by the datapath during a stage
    typedef struct packed {
        logic illegal_instr; // Decoder rejected the instruction
        logic mem_addr;      // Misaligned address
        logic mem_access;    // Bus refused the access
        logic is_store;      // Memory fault came from a store
    } fault_in_t;

    // Interrupt enables, mstatus.MIE style plus per source bits
    typedef struct packed {
        logic global_en;
        logic ext_en;
        logic sw_en;
    } irq_enable_t;

    // Trap report towards the CSR side
    typedef struct packed {
        logic       valid;        // One cycle strobe
        logic       is_interrupt; // Set for interrupts
        logic [3:0] cause;        // Exception or interrupt code
    } trap_report_t;

endpackage

/* hw/stage_sequencer.sv */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module stage_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  trap_pkg::fault_in_t     fault_in,
    input  logic                    ext_int, // Masked pending external interrupt
    input  logic                    sw_int,  // Masked pending software interrupt
    output stage_pkg::stage_vec_t   stage_active,
    output stage_pkg::control_op_e  control_op,
    output stage_pkg::fault_num_e   fault_num
);

    logic                   phase;      // High in the second cycle of a stage
    logic                   fault_q;    // Instruction was restarted by a fault
    stage_pkg::control_op_e decision_q; // Interrupt decision from end of memory
    stage_pkg::stage_vec_t  stage_rotated;

    logic                   mem_fault;
    logic                   fetch_mem_fault;
    logic                   memory_mem_fault;
    logic                   illegal_fault;
    logic                   active_fault;
    stage_pkg::fault_num_e  new_fault_num;
    stage_pkg::control_op_e next_decision;

    // Rotate left, control wraps back to fetch
    assign stage_rotated = {stage_active[`NUM_STAGES-2:0], stage_active[`NUM_STAGES-1]};

    // Fault qualification
    assign mem_fault        = fault_in.mem_addr | fault_in.mem_access;
    assign fetch_mem_fault  = mem_fault & stage_active[`STAGE_FETCH];
    assign memory_mem_fault = mem_fault & stage_active[`STAGE_MEMORY];
    assign illegal_fault    = fault_in.illegal_instr & ~stage_active[`STAGE_CONTROL];

    // Only sampled in the second cycle
    assign active_fault = phase & (fetch_mem_fault | memory_mem_fault | illegal_fault);

    // Illegal instruction first, then misaligned over access
    always_comb begin
        if (illegal_fault) begin
            new_fault_num = stage_pkg::FAULT_ILLEGAL_INSTR;
        end else if (memory_mem_fault) begin
            if (fault_in.is_store) begin
                new_fault_num = fault_in.mem_addr ? stage_pkg::FAULT_STORE_MISALIGNED
                                                  : stage_pkg::FAULT_STORE_ACCESS;
            end else begin
                new_fault_num = fault_in.mem_addr ? stage_pkg::FAULT_LOAD_MISALIGNED
                                                  : stage_pkg::FAULT_LOAD_ACCESS;
            end
        end else begin
            // Fetch side fault
            new_fault_num = fault_in.mem_addr ? stage_pkg::FAULT_INSTR_MISALIGNED
                                              : stage_pkg::FAULT_INSTR_ACCESS;
        end
    end

    // External interrupt has priority over software
    always_comb begin
        if (ext_int) begin
            next_decision = stage_pkg::CTRL_EXT_INT;
        end else if (sw_int) begin
            next_decision = stage_pkg::CTRL_SW_INT;
        end else begin
            next_decision = stage_pkg::CTRL_NORMAL;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase        <= 1'b0;
            stage_active <= `DEFAULT_STAGE_ACTIVE;
            fault_q      <= 1'b0;
            fault_num    <= stage_pkg::FAULT_INSTR_MISALIGNED;
            decision_q   <= stage_pkg::CTRL_NORMAL;
        end else begin
            phase <= ~phase;
            if (active_fault) begin
                // Abandon the instruction and restart at fetch
                stage_active <= `DEFAULT_STAGE_ACTIVE;
                fault_q      <= 1'b1;
                fault_num    <= new_fault_num;
            end else if (phase) begin
                stage_active <= stage_rotated;
                if (stage_active[`STAGE_MEMORY]) begin
                    // Decide what the control stage does
                    fault_q    <= 1'b0;
                    decision_q <= next_decision;
                end
            end
        end
    end

    // A captured fault overrides the interrupt decision
    assign control_op = fault_q ? stage_pkg::CTRL_TRAP : decision_q;

endmodule

/* hw/interrupt_latch.sv */
`timescale 1ns/1ps

module interrupt_latch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ext_irq,       // Raw external request
    input  logic                  sw_irq,        // Raw software request
    input  trap_pkg::irq_enable_t irq_enable,
    input  logic                  int_taken_ext, // Clear strobe from trap unit
    input  logic                  int_taken_sw,  // Clear strobe from trap unit
    output logic                  ext_int,
    output logic                  sw_int
);

    // Bit 1 external, bit 0 software
    logic [1:0] pending;
    logic [1:0] set_req;
    logic [1:0] clr_req;

    // Request counts only while both its enables are on
    assign set_req[1] = ext_irq & irq_enable.global_en & irq_enable.ext_en;
    assign set_req[0] = sw_irq & irq_enable.global_en & irq_enable.sw_en;

    assign clr_req = {int_taken_ext, int_taken_sw};

    // Sticky until taken, clear wins over a new request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 2'b00;
        end else begin
            pending <= (pending | set_req) & ~clr_req;
        end
    end

    // Already masked at the set side
    assign ext_int = pending[1];
    assign sw_int  = pending[0];

endmodule

/* hw/trap_cause_unit.sv */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module trap_cause_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  stage_pkg::stage_vec_t     stage_active,
    input  stage_pkg::control_op_e    control_op,
    input  stage_pkg::fault_num_e     fault_num,
    output trap_pkg::trap_report_t    trap,
    output logic [`MCAUSE_WIDTH-1:0]  mcause,
    output logic                      int_taken_ext,
    output logic                      int_taken_sw
);

    logic               prev_fetch;   // Fetch bit one cycle ago
    logic               fetch_second; // Last cycle was the second fetch cycle
    logic               fetch_start;
    logic               trap_now;
    logic               trap_valid_q;
    logic               is_int;
    stage_pkg::cause_t  cause;

    // RISC-V exception code for a captured fault
    function automatic stage_pkg::cause_t exc_code(input stage_pkg::fault_num_e f);
        stage_pkg::cause_t code;
        case (f)
            stage_pkg::FAULT_INSTR_MISALIGNED: code = 4'd0;
            stage_pkg::FAULT_INSTR_ACCESS:     code = 4'd1;
            stage_pkg::FAULT_ILLEGAL_INSTR:    code = 4'd2;
            stage_pkg::FAULT_LOAD_MISALIGNED:  code = 4'd4;
            stage_pkg::FAULT_LOAD_ACCESS:      code = 4'd5;
            stage_pkg::FAULT_STORE_MISALIGNED: code = 4'd6;
            stage_pkg::FAULT_STORE_ACCESS:     code = 4'd7;
            default:                           code = 4'd2; // Unused encoding
        endcase
        return code;
    endfunction

    // New fetch stage begins on entry or after a full two cycle fetch.
    // The second case covers a fault restart taken from fetch itself
    assign fetch_start = stage_active[`STAGE_FETCH] & (~prev_fetch | fetch_second);

    assign trap_now = fetch_start & (control_op != stage_pkg::CTRL_NORMAL);

    always_comb begin
        case (control_op)
            stage_pkg::CTRL_EXT_INT: begin
                is_int = 1'b1;
                cause  = `CAUSE_EXT_INT;
            end
            stage_pkg::CTRL_SW_INT: begin
                is_int = 1'b1;
                cause  = `CAUSE_SW_INT;
            end
            default: begin
                is_int = 1'b0;
                cause  = exc_code(fault_num);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prev_fetch    <= 1'b0;
            fetch_second  <= 1'b0;
            trap_valid_q  <= 1'b0;
            mcause        <= '0;
            int_taken_ext <= 1'b0;
            int_taken_sw  <= 1'b0;
        end else begin
            prev_fetch    <= stage_active[`STAGE_FETCH];
            fetch_second  <= stage_active[`STAGE_FETCH] & ~fetch_start;
            trap_valid_q  <= trap_now;
            int_taken_ext <= trap_now & (control_op == stage_pkg::CTRL_EXT_INT);
            int_taken_sw  <= trap_now & (control_op == stage_pkg::CTRL_SW_INT);
            if (trap_now) begin
                mcause <= {is_int, cause}; // Held until the next trap
            end
        end
    end

    // Report fields mirror the held mcause
    assign trap = '{valid: trap_valid_q, is_interrupt: mcause[4], cause: mcause[3:0]};

endmodule

/* hw/core_control.sv */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module core_control (
    input  logic                      clk,
    input  logic                      rst_n,
    input  trap_pkg::fault_in_t       fault_in,
    input  logic                      ext_irq,
    input  logic                      sw_irq,
    input  trap_pkg::irq_enable_t     irq_enable,
    output stage_pkg::stage_vec_t     stage_active,
    output stage_pkg::control_op_e    control_op,
    output trap_pkg::trap_report_t    trap,
    output logic [`MCAUSE_WIDTH-1:0]  mcause
);

    logic                  ext_int;
    logic                  sw_int;
    logic                  int_taken_ext;
    logic                  int_taken_sw;
    stage_pkg::fault_num_e fault_num;

    stage_sequencer i_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .fault_in     (fault_in),
        .ext_int      (ext_int),
        .sw_int       (sw_int),
        .stage_active (stage_active),
        .control_op   (control_op),
        .fault_num    (fault_num)
    );

    // Pending bits, cleared when the trap unit takes them
    interrupt_latch i_irq_latch (
        .clk           (clk),
        .rst_n         (rst_n),
        .ext_irq       (ext_irq),
        .sw_irq        (sw_irq),
        .irq_enable    (irq_enable),
        .int_taken_ext (int_taken_ext),
        .int_taken_sw  (int_taken_sw),
        .ext_int       (ext_int),
        .sw_int        (sw_int)
    );

    trap_cause_unit i_trap_cause (
        .clk           (clk),
        .rst_n         (rst_n),
        .stage_active  (stage_active),
        .control_op    (control_op),
        .fault_num     (fault_num),
        .trap          (trap),
        .mcause        (mcause),
        .int_taken_ext (int_taken_ext),
        .int_taken_sw  (int_taken_sw)
    );

endmodule

/* testbench/tb_core_control.sv */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module tb_core_control;

    localparam int FIELDS    = 7;  // Hex fields per scenario line
    localparam int MAX_LINES = 64;

    logic                           clk;
    logic                           rst_n;
    trap_pkg::fault_in_t            fault_in;
    logic                           ext_irq;
    logic                           sw_irq;
    trap_pkg::irq_enable_t          irq_enable;
    stage_pkg::stage_vec_t          stage_active;
    stage_pkg::control_op_e         control_op;
    trap_pkg::trap_report_t         trap;
    logic [`MCAUSE_WIDTH-1:0]       mcause;

    logic [3:0]                     stim_mem [0:511];
    logic [`MCAUSE_WIDTH-1:0]       exp_mcause; // Last reported cause, held between traps
    int                             num_lines;
    int                             timeout_limit = 50;
    int                             cycle_count = 0;
    integer                         seed = 32'h7acc;

    core_control i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .fault_in     (fault_in),
        .ext_irq      (ext_irq),
        .sw_irq       (sw_irq),
        .irq_enable   (irq_enable),
        .stage_active (stage_active),
        .control_op   (control_op),
        .trap         (trap),
        .mcause       (mcause)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Print the reason, then stop the run
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("** Error at %0t: %s is %0h, expected %0h",
                                $time, what, actual, expected));
        end
    endtask

    always @(posedge clk) begin
        if (cycle_count >= timeout_limit) begin
            abort_run($sformatf("Timeout: the tests did not finish within %0d clock cycles",
                                timeout_limit));
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    task automatic load_stimulus();
        int i;
        for (i = 0; i < 512; i++) begin
            stim_mem[9'(i)] = 4'hf; // End marker, no stage has index 15
        end
        $readmemh("testbench/core_control_stim.txt", stim_mem);
        num_lines = 0;
        while (num_lines < MAX_LINES && stim_mem[9'(num_lines * FIELDS)] != 4'hf) begin
            num_lines++;
        end
        if (num_lines == 0) begin
            abort_run("No scenarios could be read from testbench/core_control_stim.txt");
        end else begin
            timeout_limit = 24 * num_lines + 50;
        end
    endtask

    // Random fault flags only where the sequencer must ignore them
    task automatic drive_filler();
        logic [31:0] rnd;
        rnd = $random(seed);
        if (stage_active[`STAGE_CONTROL]) begin
            fault_in = rnd[3:0];
        end else if (stage_active[`STAGE_DECODE] | stage_active[`STAGE_EXECUTE]) begin
            fault_in = {1'b0, rnd[2:0]}; // Memory flags only
        end else begin
            fault_in = '0;
        end
    endtask

    // Returns at the negedge in the first cycle of a fresh visit to the stage
    task automatic wait_stage_entry(input stage_pkg::stage_vec_t mask);
        while ((stage_active & mask) != '0) begin
            drive_filler();
            @(negedge clk);
        end
        while ((stage_active & mask) == '0) begin
            drive_filler();
            @(negedge clk);
        end
    endtask

    task automatic check_rotation();
        int                    k;
        stage_pkg::stage_vec_t exp_stage;
        for (k = 0; k < 2 * `NUM_STAGES; k++) begin
            exp_stage = `DEFAULT_STAGE_ACTIVE << (k / 2); // Two cycles per stage
            check_value("stage_active after reset", 32'(stage_active), 32'(exp_stage));
            check_value("trap.valid after reset", 32'(trap.valid), 32'd0);
            check_value("control_op after reset", 32'(control_op),
                        32'(stage_pkg::CTRL_NORMAL));
            check_value("mcause after reset", 32'(mcause), 32'd0);
            @(negedge clk);
        end
    endtask

    task automatic run_scenario(input int n);
        logic [8:0]            addr;
        logic [3:0]            target;
        logic [3:0]            irq_bits;
        logic [3:0]            en_bits;
        logic                  exp_valid;
        logic                  exp_int;
        logic [3:0]            exp_cause;
        stage_pkg::stage_vec_t mask;
        addr      = 9'(n * FIELDS);
        target    = stim_mem[addr];
        irq_bits  = stim_mem[addr + 9'd2];
        en_bits   = stim_mem[addr + 9'd3];
        exp_valid = stim_mem[addr + 9'd4][0];
        exp_int   = stim_mem[addr + 9'd5][0];
        exp_cause = stim_mem[addr + 9'd6];
        if (target >= `NUM_STAGES) begin
            abort_run($sformatf("Stimulus line %0d names stage %0d, which does not exist",
                                n, target));
        end
        mask = `DEFAULT_STAGE_ACTIVE << target;
        wait_stage_entry(mask);

        // Held over both cycles of the target stage
        fault_in   = stim_mem[addr + 9'd1];
        ext_irq    = irq_bits[1];
        sw_irq     = irq_bits[0];
        irq_enable = en_bits[2:0];
        repeat (2) @(negedge clk);
        fault_in   = '0;
        ext_irq    = 1'b0;
        sw_irq     = 1'b0;
        irq_enable = '0;

        while (!stage_active[`STAGE_FETCH]) begin
            drive_filler();
            @(negedge clk);
        end
        fault_in = '0; // Fetch would take any flag as a fault
        @(negedge clk); // Report shows in the second fetch cycle

        check_value($sformatf("line %0d trap.valid", n), 32'(trap.valid), 32'(exp_valid));
        if (exp_valid) begin
            check_value($sformatf("line %0d trap.is_interrupt", n),
                        32'(trap.is_interrupt), 32'(exp_int));
            check_value($sformatf("line %0d trap.cause", n),
                        32'(trap.cause), 32'(exp_cause));
            exp_mcause = {exp_int, exp_cause};
        end
        check_value($sformatf("line %0d mcause", n), 32'(mcause), 32'(exp_mcause));

        // Strobe lasts one cycle only
        @(negedge clk);
        check_value($sformatf("line %0d trap.valid one cycle later", n),
                    32'(trap.valid), 32'd0);
    endtask

    initial begin
        int n;
        $timeformat(-9, 0, " ns", 0);
        rst_n      = 1'b0;
        fault_in   = '0;
        ext_irq    = 1'b0;
        sw_irq     = 1'b0;
        irq_enable = '0;
        exp_mcause = '0;
        load_stimulus();

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_rotation();
        for (n = 0; n < num_lines; n++) begin
            run_scenario(n);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* testbench/core_control_stim.txt */
// Columns: stage fault_in irq(ext,sw) irq_enable(global,ext,sw) trap_valid is_interrupt cause
// fault_in bits: illegal_instr mem_addr mem_access is_store, every field one hex digit
0 4 0 0 1 0 0
0 2 0 0 1 0 1
0 6 0 0 1 0 0
0 8 0 0 1 0 2
0 c 0 0 1 0 2
3 4 0 0 1 0 4
3 2 0 0 1 0 5
3 5 0 0 1 0 6
3 3 0 0 1 0 7
3 6 0 0 1 0 4
3 7 0 0 1 0 6
3 b 0 0 1 0 2
1 8 0 0 1 0 2
2 9 0 0 1 0 2
1 6 0 0 0 0 0
2 7 0 0 0 0 0
4 8 0 0 0 0 0
4 f 0 0 0 0 0
1 4 0 0 0 0 0
1 0 2 7 1 1 b
2 0 1 7 1 1 3
0 0 3 7 1 1 b
3 0 0 0 1 1 3
2 0 0 0 0 0 0
3 0 2 6 1 1 b
3 0 1 5 1 1 3
1 0 2 3 0 0 0
1 0 1 3 0 0 0
2 0 2 5 0 0 0
2 0 1 6 0 0 0
0 0 3 0 0 0 0
4 0 1 7 0 0 0
3 0 0 0 1 1 3
0 4 0 0 1 0 0

/* filelist.f */
+incdir+hw
hw/stage_pkg.sv
hw/trap_pkg.sv
hw/stage_sequencer.sv
hw/interrupt_latch.sv
hw/trap_cause_unit.sv
hw/core_control.sv
testbench/tb_core_control.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator from the project root, run, then search the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
    --top-module tb_core_control -Mdir obj_dir -o sim_core_control \
    && ./obj_dir/sim_core_control > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "^PASS: all tests$" sim.log \
    && echo "Simulation result: passed" \
    || { echo "Simulation result: failed"; exit 1; }
